/* hw/mem_layout_pkg.sv */
package mem_layout_pkg;

  // narrow beat buses and the wide words they carry
  parameter int A_BUS_WIDTH   = 8;
  parameter int A_DATA_WIDTH  = 32;
  parameter int WD_BUS_WIDTH  = 16;
  parameter int WD_DATA_WIDTH = 32;

  parameter int ADDR_NUM = 4; // regions in the memory map

  typedef enum logic [2:0] {
    MEM_INSTR,
    MEM_DATA,
    MEM_STACK,
    MEM_MMIO,
    MEM_NONE // address outside every region
  } mem_id_e;

  // regions must not overlap
  parameter logic [A_DATA_WIDTH-1:0] region_base [ADDR_NUM] = '{
    32'h0000_0000, // instruction memory
    32'h1000_0000, // data memory
    32'h7fff_0000, // stack
    32'h8000_0000  // mmio window
  };

  parameter logic [A_DATA_WIDTH-1:0] region_size [ADDR_NUM] = '{
    32'h0001_0000,
    32'h0004_0000,
    32'h0001_0000,
    32'h0000_1000
  };

  parameter mem_id_e region_id [ADDR_NUM] = '{
    MEM_INSTR,
    MEM_DATA,
    MEM_STACK,
    MEM_MMIO
  };

  typedef enum logic [1:0] {
    TX_IDLE,         // ready for a new word
    TX_REQ,          // req high, waiting for ack
    TX_WAIT_ACK_LOW  // req dropped, waiting for ack to fall
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE, // waiting for req, or word complete
    RX_ACK,  // ack high, waiting for req to fall
    RX_HOLD  // word presented until consumed
  } rx_state_e;

endpackage

/* hw/axi_transmit.sv */
`timescale 1ns/1ps

module axi_transmit
  import mem_layout_pkg::*;
#(
  parameter int BUS_WIDTH  = 8,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  send,
  input  logic [DATA_WIDTH-1:0] data_to_send,
  output logic                  trans_rdy,
  output logic [BUS_WIDTH-1:0]  beat_data,
  output logic                  req,
  input  logic                  ack
);

  localparam int BEATS = DATA_WIDTH / BUS_WIDTH;
  localparam int CNT_W = $clog2(BEATS + 1);

  tx_state_e             state;
  logic [CNT_W-1:0]      beat_cnt;
  logic [DATA_WIDTH-1:0] shift_word; // low slice is the beat on the bus
  logic                  last_beat;

  assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

  assign trans_rdy = (state == TX_IDLE);
  assign req       = (state == TX_REQ);
  assign beat_data = shift_word[BUS_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (send) begin
            state    <= TX_REQ;
            beat_cnt <= '0;
          end
        end
        TX_REQ: begin
          if (ack) state <= TX_WAIT_ACK_LOW; // receiver has the beat
        end
        TX_WAIT_ACK_LOW: begin
          if (!ack) begin
            if (last_beat) begin
              state <= TX_IDLE;
            end else begin
              state    <= TX_REQ; // next beat goes out right away
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // word register, shifted one beat down between handshakes
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && send) begin
      shift_word <= data_to_send;
    end else if (state == TX_WAIT_ACK_LOW && !ack && !last_beat) begin
      shift_word <= shift_word >> BUS_WIDTH;
    end
  end

endmodule

/* hw/axi_receive.sv */
`timescale 1ns/1ps

module axi_receive
  import mem_layout_pkg::*;
#(
  parameter int BUS_WIDTH  = 8,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [BUS_WIDTH-1:0]  beat_data,
  input  logic                  req,
  output logic                  ack,
  output logic [DATA_WIDTH-1:0] data,
  output logic                  valid_data,
  input  logic                  dev_rdy
);

  localparam int BEATS = DATA_WIDTH / BUS_WIDTH;
  localparam int CNT_W = $clog2(BEATS + 1);

  rx_state_e             state;
  logic [CNT_W-1:0]      beat_cnt; // beats captured so far
  logic [DATA_WIDTH-1:0] assembly;
  logic                  word_done;
  logic                  capture;

  assign word_done = (beat_cnt == CNT_W'(BEATS));
  assign capture   = (state == RX_IDLE) && !word_done && req;

  assign ack        = (state == RX_ACK);
  assign valid_data = (state == RX_HOLD);
  assign data       = assembly;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (word_done) begin
            state    <= RX_HOLD; // one cycle after the final ack falls
            beat_cnt <= '0;
          end else if (req) begin
            state <= RX_ACK;
          end
        end
        RX_ACK: begin
          if (!req) begin
            state    <= RX_IDLE;
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        RX_HOLD: begin
          // no ack is raised here, so a new word stalls at req
          if (dev_rdy) state <= RX_IDLE;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // beats arrive least significant first
  always_ff @(posedge clk) begin
    if (capture) begin
      assembly[beat_cnt * BUS_WIDTH +: BUS_WIDTH] <= beat_data;
    end
  end

endmodule

/* hw/mem_id_decode.sv */
`timescale 1ns/1ps

module mem_id_decode
  import mem_layout_pkg::*;
(
  input  logic [A_DATA_WIDTH-1:0] addr,
  output mem_id_e                 mem_id
);

  logic [ADDR_NUM-1:0] hit;

  // offset compare keeps base plus size from wrapping at the top of the map
  always_comb begin
    for (int i = 0; i < ADDR_NUM; i++) begin
      hit[i] = (addr >= region_base[i]) &&
               ((addr - region_base[i]) < region_size[i]);
    end
  end

  always_comb begin
    mem_id = MEM_NONE;
    for (int i = 0; i < ADDR_NUM; i++) begin
      if (hit[i]) mem_id = region_id[i]; // regions are disjoint
    end
  end

endmodule

/* hw/axi_chan_link.sv */
`timescale 1ns/1ps

module axi_chan_link
  import mem_layout_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     a_send,
  input  logic [A_DATA_WIDTH-1:0]  a_data_to_send,
  output logic                     a_trans_rdy,
  output logic [A_DATA_WIDTH-1:0]  a_data,
  output mem_id_e                  a_mem_id,
  output logic                     a_valid_data,
  input  logic                     a_dev_rdy,
  input  logic                     wd_send,
  input  logic [WD_DATA_WIDTH-1:0] wd_data_to_send,
  output logic                     wd_trans_rdy,
  output logic [WD_DATA_WIDTH-1:0] wd_data,
  output logic                     wd_valid_data,
  input  logic                     wd_dev_rdy
);

  logic [A_BUS_WIDTH-1:0]  a_beat;
  logic                    a_req;
  logic                    a_ack;
  logic [WD_BUS_WIDTH-1:0] wd_beat;
  logic                    wd_req;
  logic                    wd_ack;

  // address channel
  axi_transmit #(.BUS_WIDTH(A_BUS_WIDTH), .DATA_WIDTH(A_DATA_WIDTH)) addr_transmit (
    .clk          (clk),
    .rst          (rst),
    .send         (a_send),
    .data_to_send (a_data_to_send),
    .trans_rdy    (a_trans_rdy),
    .beat_data    (a_beat),
    .req          (a_req),
    .ack          (a_ack)
  );

  axi_receive #(.BUS_WIDTH(A_BUS_WIDTH), .DATA_WIDTH(A_DATA_WIDTH)) addr_receive (
    .clk        (clk),
    .rst        (rst),
    .beat_data  (a_beat),
    .req        (a_req),
    .ack        (a_ack),
    .data       (a_data),
    .valid_data (a_valid_data),
    .dev_rdy    (a_dev_rdy)
  );

  mem_id_decode u_mem_id_decode (
    .addr   (a_data),
    .mem_id (a_mem_id)
  );

  // write-data channel, independent of the address path
  axi_transmit #(.BUS_WIDTH(WD_BUS_WIDTH), .DATA_WIDTH(WD_DATA_WIDTH)) wd_transmit (
    .clk          (clk),
    .rst          (rst),
    .send         (wd_send),
    .data_to_send (wd_data_to_send),
    .trans_rdy    (wd_trans_rdy),
    .beat_data    (wd_beat),
    .req          (wd_req),
    .ack          (wd_ack)
  );

  axi_receive #(.BUS_WIDTH(WD_BUS_WIDTH), .DATA_WIDTH(WD_DATA_WIDTH)) wd_receive (
    .clk        (clk),
    .rst        (rst),
    .beat_data  (wd_beat),
    .req        (wd_req),
    .ack        (wd_ack),
    .data       (wd_data),
    .valid_data (wd_valid_data),
    .dev_rdy    (wd_dev_rdy)
  );

endmodule

/* dv/axi_chan_link_tb.sv */
`timescale 1ns/1ps

module axi_chan_link_tb
  import mem_layout_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  // words sent over all tests
  localparam int NUM_WORDS  = 3 * ADDR_NUM + 24 + 2 + WD_DATA_WIDTH + 32 + 2 + 8;
  localparam int TIMEOUT_NS = (NUM_WORDS * 40 + 400) * CLK_PERIOD;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     a_send;
  logic [A_DATA_WIDTH-1:0]  a_data_to_send;
  logic                     a_trans_rdy;
  logic [A_DATA_WIDTH-1:0]  a_data;
  mem_id_e                  a_mem_id;
  logic                     a_valid_data;
  logic                     a_dev_rdy;
  logic                     wd_send;
  logic [WD_DATA_WIDTH-1:0] wd_data_to_send;
  logic                     wd_trans_rdy;
  logic [WD_DATA_WIDTH-1:0] wd_data;
  logic                     wd_valid_data;
  logic                     wd_dev_rdy;

  int errors = 0;
  int checks = 0;

  axi_chan_link u_axi_chan_link (
    .clk             (clk),
    .rst             (rst),
    .a_send          (a_send),
    .a_data_to_send  (a_data_to_send),
    .a_trans_rdy     (a_trans_rdy),
    .a_data          (a_data),
    .a_mem_id        (a_mem_id),
    .a_valid_data    (a_valid_data),
    .a_dev_rdy       (a_dev_rdy),
    .wd_send         (wd_send),
    .wd_data_to_send (wd_data_to_send),
    .wd_trans_rdy    (wd_trans_rdy),
    .wd_data         (wd_data),
    .wd_valid_data   (wd_valid_data),
    .wd_dev_rdy      (wd_dev_rdy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // region i holds addr when base <= addr < base + size without wrapping the sum
  function automatic mem_id_e expected_mem_id(input logic [A_DATA_WIDTH-1:0] addr);
    logic [A_DATA_WIDTH:0] lo;
    logic [A_DATA_WIDTH:0] hi;
    expected_mem_id = MEM_NONE;
    for (int i = 0; i < ADDR_NUM; i++) begin
      lo = {1'b0, region_base[i]};
      hi = lo + {1'b0, region_size[i]};
      if ({1'b0, addr} >= lo && {1'b0, addr} < hi) expected_mem_id = region_id[i];
    end
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input mem_id_e got, input logic [A_DATA_WIDTH-1:0] addr);
    mem_id_e exp;
    exp = expected_mem_id(addr);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: a_mem_id for %h is %s, expected %s",
               $time, addr, got.name(), exp.name());
    end
  endtask

  // sample on the falling edge and drive on the rising edge
  task automatic start_addr(input logic [A_DATA_WIDTH-1:0] addr);
    @(negedge clk);
    while (!a_trans_rdy) @(negedge clk);
    @(posedge clk);
    a_send         <= 1'b1;
    a_data_to_send <= addr;
    @(posedge clk);
    a_send <= 1'b0;
  endtask

  task automatic start_data(input logic [WD_DATA_WIDTH-1:0] word);
    @(negedge clk);
    while (!wd_trans_rdy) @(negedge clk);
    @(posedge clk);
    wd_send         <= 1'b1;
    wd_data_to_send <= word;
    @(posedge clk);
    wd_send <= 1'b0;
  endtask

  task automatic send_addr(input logic [A_DATA_WIDTH-1:0] addr);
    start_addr(addr);
    @(negedge clk);
    while (!a_valid_data) @(negedge clk);
    check_word("a_data", a_data, addr);
    check_id(a_mem_id, addr);
  endtask

  task automatic send_data(input logic [WD_DATA_WIDTH-1:0] word);
    start_data(word);
    @(negedge clk);
    while (!wd_valid_data) @(negedge clk);
    check_word("wd_data", wd_data, word);
  endtask

  task automatic reset_check();
    @(negedge clk);
    check_flag("a_trans_rdy after reset", a_trans_rdy, 1'b1);
    check_flag("wd_trans_rdy after reset", wd_trans_rdy, 1'b1);
    check_flag("a_valid_data after reset", a_valid_data, 1'b0);
    check_flag("wd_valid_data after reset", wd_valid_data, 1'b0);
  endtask

  task automatic decode_regions();
    for (int i = 0; i < ADDR_NUM; i++) begin
      send_addr(region_base[i]);
      send_addr(region_base[i] + region_size[i] - 1); // last byte of the region
    end
  endtask

  task automatic unmapped_addrs();
    logic [A_DATA_WIDTH-1:0] addr;
    int found;
    // the stack ends right at the mmio base so that address still decodes as mmio
    for (int i = 0; i < ADDR_NUM; i++) send_addr(region_base[i] + region_size[i]);
    found = 0;
    while (found < 24) begin
      addr = $urandom();
      if (expected_mem_id(addr) == MEM_NONE) begin
        send_addr(addr);
        found++;
      end
    end
  endtask

  task automatic data_round_trip();
    send_data('0);
    send_data('1);
    for (int b = 0; b < WD_DATA_WIDTH; b++) send_data(32'h1 << b); // walking one
    repeat (32) send_data($urandom());
  endtask

  task automatic backpressure_check();
    logic [WD_DATA_WIDTH-1:0] first;
    logic [WD_DATA_WIDTH-1:0] second;
    int hold;
    first  = $urandom();
    second = $urandom();
    hold   = $urandom_range(20, 5);
    @(posedge clk);
    wd_dev_rdy <= 1'b0;
    start_data(first);
    @(negedge clk);
    while (!wd_valid_data) @(negedge clk);
    start_data(second); // stalls at req behind the held word
    repeat (hold) begin
      @(negedge clk);
      check_flag("wd_valid_data while held", wd_valid_data, 1'b1);
      check_word("wd_data while held", wd_data, first);
    end
    @(posedge clk);
    wd_dev_rdy <= 1'b1;
    @(negedge clk);
    while (wd_valid_data) @(negedge clk);
    while (!wd_valid_data) @(negedge clk);
    check_word("wd_data after release", wd_data, second);
    repeat (20) begin
      @(negedge clk);
      check_flag("wd_valid_data with no word pending", wd_valid_data, 1'b0);
    end
  endtask

  task automatic send_both(input logic [A_DATA_WIDTH-1:0] addr,
                           input logic [WD_DATA_WIDTH-1:0] word);
    logic got_a;
    logic got_wd;
    got_a  = 1'b0;
    got_wd = 1'b0;
    @(negedge clk);
    while (!(a_trans_rdy && wd_trans_rdy)) @(negedge clk);
    @(posedge clk);
    a_send          <= 1'b1;
    a_data_to_send  <= addr;
    wd_send         <= 1'b1;
    wd_data_to_send <= word;
    @(posedge clk);
    a_send  <= 1'b0;
    wd_send <= 1'b0;
    while (!(got_a && got_wd)) begin
      @(negedge clk);
      if (a_valid_data && !got_a) begin
        got_a = 1'b1;
        check_word("a_data", a_data, addr);
        check_id(a_mem_id, addr);
      end
      if (wd_valid_data && !got_wd) begin
        got_wd = 1'b1;
        check_word("wd_data", wd_data, word);
      end
    end
  endtask

  task automatic concurrent_words();
    logic [A_DATA_WIDTH-1:0] addr;
    for (int k = 0; k < 8; k++) begin
      addr = region_base[k % ADDR_NUM] + ($urandom() % region_size[k % ADDR_NUM]);
      send_both(addr, $urandom());
    end
  endtask

  initial begin
    int unsigned seed_init;
    seed_init       = $urandom(8906);
    rst             = 1'b1;
    a_send          = 1'b0;
    a_data_to_send  = '0;
    a_dev_rdy       = 1'b1;
    wd_send         = 1'b0;
    wd_data_to_send = '0;
    wd_dev_rdy      = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    reset_check();
    decode_regions();
    unmapped_addrs();
    data_round_trip();
    backpressure_check();
    concurrent_words();
    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

/* axi_chan_link.f */
hw/mem_layout_pkg.sv
hw/axi_transmit.sv
hw/axi_receive.sv
hw/mem_id_decode.sv
hw/axi_chan_link.sv
dv/axi_chan_link_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = axi_chan_link_tb
FILELIST  = axi_chan_link.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run counts as passed only if the pass message is in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
